// File: bench/slice_patterns.txt
// test op op_mod fmt vectorial tag operand_a operand_b expected_result expected_nv
// op 0 sgnj 1 sgnjn 2 sgnjx 3 minmax; fmt 0 FP32 1 FP16; tag is line index mod 16
2 0 0 0 0 0 123456783F800000 00000000C0000000 FFFFFFFFBF800000 0
2 1 0 0 0 1 00000000BF800000 00000000C0000000 FFFFFFFF3F800000 0
2 2 0 0 0 2 00000000C0490FDB 0000000080000000 FFFFFFFF40490FDB 0
2 2 0 0 0 3 0000000040490FDB 00000000BF800000 FFFFFFFFC0490FDB 0
2 0 0 1 0 4 1111222233333C00 444455556666C000 FFFFFFFFFFFFBC00 0
2 1 0 1 0 5 0000000000003C00 0000000000004000 FFFFFFFFFFFFBC00 0
2 2 0 1 0 6 000000000000C500 000000000000C000 FFFFFFFFFFFF4500 0
2 1 0 1 0 7 0000000000007D00 0000000000000000 FFFFFFFFFFFFFD00 0
3 3 0 1 1 8 BC007E0080003C00 C000C00000004000 C000C00080003C00 0
3 3 1 1 1 9 BC007E0080003C00 C000C00000004000 BC00C00000004000 0
3 3 0 1 1 A FC007E5556400000 7C00FF0056408000 FC007E0056408000 0
3 3 0 0 1 B 000000003F800000 80000000BF800000 80000000BF800000 0
3 3 1 0 1 C 7FC000017FC00000 FFC00000C1200000 7FC00000C1200000 0
3 3 1 0 1 D C000000040490FDB C0490FDB40000000 C000000040490FDB 0
3 3 1 0 0 E 012345673F800000 0000000040000000 FFFFFFFF40000000 0
3 3 0 1 0 F 0000000000004000 0000000000003C00 FFFFFFFFFFFF3C00 0
4 3 0 1 1 0 C4007D0040003C00 44003C0042003800 C4003C0040003800 1
4 3 0 1 1 1 C4007E0040003C00 44003C0042003800 C4003C0040003800 0
4 3 1 0 1 2 3F800000BF800000 7F80000100000000 3F80000000000000 1
4 3 1 0 1 3 3F800000BF800000 3F00000000000000 3F80000000000000 0
4 3 0 1 1 4 7BFF35557D000001 FBFF35557C010002 FBFF35557E000001 1
4 3 0 1 0 5 7D007D007D003C00 7C017C017C014000 FFFFFFFFFFFF3C00 0
5 2 0 1 1 6 3C00BC004000C000 8000800000000000 BC003C004000C000 0
5 1 0 0 1 7 3F80000040000000 0000000080000000 BF80000040000000 0
5 0 0 0 1 8 BF800000C0000000 0000000000000000 3F80000040000000 0
5 3 1 1 1 9 0000800000018001 8000000080010001 0000000000010001 0

// File: bench/slice_tb.sv
/*
  Testbench for the multi-format SIMD slice
  Streams table-driven operations under random output stalls and checks
  results, invalid flags and tags in acceptance order
*/
module slice_tb;

  localparam int unsigned WIDTH      = 64;
  localparam int unsigned NUM_FIELDS = 10;   // Columns per pattern line
  localparam int unsigned MAX_PATS   = 64;
  localparam int unsigned TIMEOUT    = 200;  // Cycles allowed for any single wait

  logic                           clk_i;
  logic                           arst_n_i;
  logic [WIDTH-1:0]               operand_a_i;
  logic [WIDTH-1:0]               operand_b_i;
  slice_pkg::slice_ctrl_t         ctrl_i;
  logic                           in_valid_i;
  logic                           in_ready_o;
  logic [WIDTH-1:0]               result_o;
  logic                           nv_o;
  logic [slice_pkg::TAG_BITS-1:0] tag_o;
  logic                           out_valid_o;
  logic                           out_ready_i;
  logic                           busy_o;

  logic [63:0] pat_mem [0:NUM_FIELDS*MAX_PATS-1];
  int          num_pats;
  int          pass_count;
  int          fail_count;
  int          seed = 96351;
  logic        all_seen;  // Scoreboard has taken every item

  multifmt_slice multifmt_slice_i (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .operand_a_i ( operand_a_i ),
    .operand_b_i ( operand_b_i ),
    .ctrl_i      ( ctrl_i      ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .result_o    ( result_o    ),
    .nv_o        ( nv_o        ),
    .tag_o       ( tag_o       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  always #4 clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Pattern table
  // --------------------------------------------------------------------------
  task automatic load_patterns();
    $readmemh("bench/slice_patterns.txt", pat_mem);
    num_pats = 0;
    // Test numbers start at 1, so an unloaded or zero entry ends the table
    while (num_pats < MAX_PATS && !$isunknown(pat_mem[num_pats*NUM_FIELDS])
           && pat_mem[num_pats*NUM_FIELDS] != 0) begin
      num_pats++;
    end
    if (num_pats == 0) begin
      $display("No patterns could be loaded from the pattern file");
      fail_count++;
    end
  endtask

  task automatic check_reset_state();
    if (out_valid_o !== 1'b0 || busy_o !== 1'b0 || in_ready_o !== 1'b1) begin
      $display("FAILED reset state: expected valid 0 busy 0 ready 1 actual valid %b busy %b ready %b",
               out_valid_o, busy_o, in_ready_o);
      fail_count++;
    end else begin
      $display("ok reset state");
      pass_count++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Driver and scoreboard
  // --------------------------------------------------------------------------
  task automatic drive_items();
    int   waited;
    logic accepted;
    for (int k = 0; k < num_pats; k++) begin
      operand_a_i      = pat_mem[k*NUM_FIELDS+6];
      operand_b_i      = pat_mem[k*NUM_FIELDS+7];
      ctrl_i.op        = slice_pkg::operation_e'(pat_mem[k*NUM_FIELDS+1][1:0]);
      ctrl_i.op_mod    = pat_mem[k*NUM_FIELDS+2][0];
      ctrl_i.fmt       = slice_pkg::fp_format_e'(pat_mem[k*NUM_FIELDS+3][0]);
      ctrl_i.vectorial = pat_mem[k*NUM_FIELDS+4][0];
      ctrl_i.tag       = 4'(k % 16);
      in_valid_i       = 1'b1;
      waited   = 0;
      accepted = 1'b0;
      while (!accepted && waited < TIMEOUT) begin
        @(posedge clk_i);
        waited++;
        accepted = in_ready_o;  // Valid is high, so ready alone decides the transfer
      end
      if (!accepted) begin
        $display("Timed out waiting for the slice to accept item %0d", k);
        fail_count++;
        break;
      end
      #1;
    end
    in_valid_i = 1'b0;
  endtask

  task automatic compare_item(input int k);
    logic [WIDTH-1:0] exp_result;
    logic             exp_nv;
    logic [3:0]       exp_tag;
    int               test_num;
    logic             item_ok;
    test_num   = int'(pat_mem[k*NUM_FIELDS]);
    exp_tag    = pat_mem[k*NUM_FIELDS+5][3:0];
    exp_result = pat_mem[k*NUM_FIELDS+8];
    exp_nv     = pat_mem[k*NUM_FIELDS+9][0];
    item_ok    = 1'b1;
    if (result_o !== exp_result) begin
      $display("FAILED test %0d item %0d result: expected %h actual %h",
               test_num, k, exp_result, result_o);
      item_ok = 1'b0;
    end
    if (nv_o !== exp_nv) begin
      $display("FAILED test %0d item %0d nv: expected %b actual %b", test_num, k, exp_nv, nv_o);
      item_ok = 1'b0;
    end
    if (tag_o !== exp_tag) begin
      $display("FAILED test %0d item %0d tag: expected %h actual %h", test_num, k, exp_tag, tag_o);
      item_ok = 1'b0;
    end
    if (item_ok) begin
      $display("ok test %0d item %0d", test_num, k);
      pass_count++;
    end else begin
      fail_count++;
    end
  endtask

  task automatic check_items();
    int   waited;
    logic taken;
    for (int k = 0; k < num_pats; k++) begin
      waited = 0;
      taken  = 1'b0;
      while (!taken && waited < TIMEOUT) begin
        @(posedge clk_i);
        waited++;
        taken = out_valid_o && out_ready_i;
      end
      if (!taken) begin
        $display("Timed out waiting for the result of item %0d", k);
        fail_count++;
        break;
      end
      compare_item(k);
    end
    all_seen = 1'b1;
  endtask

  // Random stalls, about one cycle in four
  task automatic drive_out_ready();
    int cycles;
    cycles = 0;
    while (!all_seen && cycles < TIMEOUT * MAX_PATS) begin
      @(posedge clk_i);
      #1;
      out_ready_i = ($random(seed) & 3) != 0;
      cycles++;
    end
    out_ready_i = 1'b1;
  endtask

  task automatic check_drain();
    int waited;
    waited = 0;
    while (busy_o && waited < TIMEOUT) begin
      @(posedge clk_i);
      waited++;
    end
    if (busy_o !== 1'b0 || out_valid_o !== 1'b0) begin
      $display("The slice stayed busy after the last item had left");
      fail_count++;
    end else begin
      $display("ok drain");
      pass_count++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin : run
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    ctrl_i      = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    all_seen    = 1'b0;
    pass_count  = 0;
    fail_count  = 0;
    load_patterns();
    repeat (16) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    check_reset_state();
    fork
      drive_items();
      check_items();
      drive_out_ready();
    join
    check_drain();
    $display("Tests run: %0d, passed: %0d, failed: %0d",
             pass_count + fail_count, pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: flist.f
verilog/slice_pkg.sv
verilog/lane_dispatch.sv
verilog/sgnj_minmax_core.sv
verilog/slice_lane.sv
verilog/result_pack.sv
verilog/multifmt_slice.sv
bench/slice_tb.sv

// File: verilog/lane_dispatch.sv
/*
  Lane dispatch
  Slices both operands into per-lane requests and marks the lanes in use
*/
module lane_dispatch #(
  parameter int unsigned  Width     = 64,
  localparam int unsigned NUM_LANES = Width / slice_pkg::SLOT_BITS
) (
  input  logic [Width-1:0]                      operand_a_i,
  input  logic [Width-1:0]                      operand_b_i,
  input  slice_pkg::slice_ctrl_t                ctrl_i,
  output slice_pkg::lane_req_t [NUM_LANES-1:0]  lane_req_o
);

  localparam int unsigned NUM_FP32_SLOTS = Width / slice_pkg::FP32_BITS;
  localparam int unsigned NUM_FP16_SLOTS = Width / slice_pkg::FP16_BITS;

  logic [NUM_LANES-1:0] lane_active;

  always_comb begin : slice_operands
    int unsigned      slot_bits;
    int unsigned      num_slots;
    logic [Width-1:0] shifted_a;
    logic [Width-1:0] shifted_b;

    slot_bits = (ctrl_i.fmt == slice_pkg::FP32) ? slice_pkg::FP32_BITS : slice_pkg::FP16_BITS;
    num_slots = (ctrl_i.fmt == slice_pkg::FP32) ? NUM_FP32_SLOTS : NUM_FP16_SLOTS;

    for (int unsigned lane = 0; lane < NUM_LANES; lane++) begin
      // Slot n starts at n times the format width
      shifted_a = operand_a_i >> (lane * slot_bits);
      shifted_b = operand_b_i >> (lane * slot_bits);

      // Lane 0 always runs, upper lanes only for vectors that reach them
      lane_active[lane] = (lane == 0) || (ctrl_i.vectorial && (lane < num_slots));

      lane_req_o[lane].a      = shifted_a[slice_pkg::LANE_BITS-1:0];
      lane_req_o[lane].b      = shifted_b[slice_pkg::LANE_BITS-1:0];
      lane_req_o[lane].op     = ctrl_i.op;
      lane_req_o[lane].op_mod = ctrl_i.op_mod;
      lane_req_o[lane].fmt    = ctrl_i.fmt;
      lane_req_o[lane].active = lane_active[lane];
    end
  end

endmodule

// File: verilog/multifmt_slice.sv
/*
  Multi-format SIMD slice
  Sign injection and min/max on FP32/FP16 lanes with a valid/ready pipeline
*/
module multifmt_slice #(
  parameter int unsigned Width       = 64,
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic [Width-1:0]               operand_a_i,
  input  logic [Width-1:0]               operand_b_i,
  input  slice_pkg::slice_ctrl_t         ctrl_i,
  input  logic                           in_valid_i,
  output logic                           in_ready_o,
  output logic [Width-1:0]               result_o,
  output logic                           nv_o,
  output logic [slice_pkg::TAG_BITS-1:0] tag_o,
  output logic                           out_valid_o,
  input  logic                           out_ready_i,
  output logic                           busy_o
);

  localparam int unsigned NUM_LANES = Width / slice_pkg::SLOT_BITS;

  slice_pkg::lane_req_t [NUM_LANES-1:0] lane_req;
  slice_pkg::lane_rsp_t [NUM_LANES-1:0] lane_rsp;
  logic [NUM_LANES-1:0]                 lane_in_ready;
  logic [NUM_LANES-1:0]                 lane_out_valid;
  logic [NUM_LANES-1:0]                 lane_busy;

  lane_dispatch #(
    .Width ( Width )
  ) i_lane_dispatch (
    .operand_a_i ( operand_a_i ),
    .operand_b_i ( operand_b_i ),
    .ctrl_i      ( ctrl_i      ),
    .lane_req_o  ( lane_req    )
  );

  // Every lane sees the shared handshake, which keeps them in lockstep
  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_lanes
    slice_lane #(
      .NumPipeRegs ( NumPipeRegs )
    ) i_slice_lane (
      .clk_i       ( clk_i                ),
      .arst_n_i    ( arst_n_i             ),
      .req_i       ( lane_req[lane]       ),
      .ctrl_i      ( ctrl_i               ),
      .in_valid_i  ( in_valid_i           ),
      .in_ready_o  ( lane_in_ready[lane]  ),
      .rsp_o       ( lane_rsp[lane]       ),
      .out_valid_o ( lane_out_valid[lane] ),
      .out_ready_i ( out_ready_i          ),
      .busy_o      ( lane_busy[lane]      )
    );
  end

  assign in_ready_o  = lane_in_ready[0];   // Lane 0 speaks for all
  assign out_valid_o = lane_out_valid[0];

  result_pack #(
    .Width ( Width )
  ) i_result_pack (
    .lane_rsp_i  ( lane_rsp  ),
    .lane_busy_i ( lane_busy ),
    .result_o    ( result_o  ),
    .nv_o        ( nv_o      ),
    .tag_o       ( tag_o     ),
    .busy_o      ( busy_o    )
  );

endmodule

// File: verilog/result_pack.sv
/*
  Result packing
  Places active lane slots into the output word, NaN-boxes the rest,
  collapses the invalid flag and picks tag and busy
*/
module result_pack #(
  parameter int unsigned  Width     = 64,
  localparam int unsigned NUM_LANES = Width / slice_pkg::SLOT_BITS
) (
  input  slice_pkg::lane_rsp_t [NUM_LANES-1:0]  lane_rsp_i,
  input  logic [NUM_LANES-1:0]                  lane_busy_i,
  output logic [Width-1:0]                      result_o,
  output logic                                  nv_o,
  output logic [slice_pkg::TAG_BITS-1:0]        tag_o,
  output logic                                  busy_o
);

  localparam int unsigned NUM_FP32_SLOTS = Width / slice_pkg::FP32_BITS;

  slice_pkg::lane_rsp_t head;  // Lane 0 describes the whole item

  assign head = lane_rsp_i[0];

  always_comb begin : pack
    result_o = '1;  // NaN-boxing for every slot not written below
    nv_o     = 1'b0;

    for (int unsigned i = 0; i < NUM_LANES; i++) begin
      if (lane_rsp_i[i].active && ((i == 0) || head.vectorial)) begin
        nv_o = nv_o | lane_rsp_i[i].nv;

        if (head.fmt == slice_pkg::FP32) begin
          if (i < NUM_FP32_SLOTS) begin
            result_o[i*slice_pkg::FP32_BITS +: slice_pkg::FP32_BITS] = lane_rsp_i[i].result;
          end
        end else begin
          result_o[i*slice_pkg::FP16_BITS +: slice_pkg::FP16_BITS] =
              lane_rsp_i[i].result[slice_pkg::FP16_BITS-1:0];
        end
      end
    end
  end

  assign tag_o  = head.tag;
  assign busy_o = |lane_busy_i;  // Any lane still holding data

endmodule

// File: verilog/sgnj_minmax_core.sv
/*
  Sign injection and min/max for one lane
  Works on FP32 or FP16, FP16 results come back NaN-boxed
*/
module sgnj_minmax_core (
  input  slice_pkg::lane_req_t             req_i,
  output logic [slice_pkg::LANE_BITS-1:0]  result_o,
  output logic                             nv_o
);

  localparam logic [31:0] CANON_NAN32 = 32'h7FC0_0000;
  localparam logic [15:0] CANON_NAN16 = 16'h7E00;

  logic [slice_pkg::LANE_BITS-1:0] val_a;   // Operands right-aligned at format width
  logic [slice_pkg::LANE_BITS-1:0] val_b;
  logic [slice_pkg::LANE_BITS-2:0] mag_a;
  logic [slice_pkg::LANE_BITS-2:0] mag_b;
  logic                            sign_a;
  logic                            sign_b;
  logic                            nan_a;
  logic                            nan_b;
  logic                            snan_a;
  logic                            snan_b;
  logic                            a_lt_b;
  logic                            inj_sign;
  logic [slice_pkg::LANE_BITS-1:0] res_val;

  // ---------------------------------------------------------------------------
  // Operand decode
  // ---------------------------------------------------------------------------
  always_comb begin : unpack
    if (req_i.fmt == slice_pkg::FP32) begin
      val_a  = req_i.a;
      val_b  = req_i.b;
      sign_a = req_i.a[31];
      sign_b = req_i.b[31];
      mag_a  = req_i.a[30:0];
      mag_b  = req_i.b[30:0];
      nan_a  = (req_i.a[30:23] == '1) && (req_i.a[22:0] != '0);
      nan_b  = (req_i.b[30:23] == '1) && (req_i.b[22:0] != '0);
      snan_a = nan_a && !req_i.a[22];  // Quiet bit clear
      snan_b = nan_b && !req_i.b[22];
    end else begin
      val_a  = {16'h0, req_i.a[15:0]};
      val_b  = {16'h0, req_i.b[15:0]};
      sign_a = req_i.a[15];
      sign_b = req_i.b[15];
      mag_a  = {16'h0, req_i.a[14:0]};
      mag_b  = {16'h0, req_i.b[14:0]};
      nan_a  = (req_i.a[14:10] == '1) && (req_i.a[9:0] != '0);
      nan_b  = (req_i.b[14:10] == '1) && (req_i.b[9:0] != '0);
      snan_a = nan_a && !req_i.a[9];
      snan_b = nan_b && !req_i.b[9];
    end
  end

  // Sign-magnitude order, so -0 sorts below +0
  always_comb begin : compare
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b;
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  // ---------------------------------------------------------------------------
  // Operation
  // ---------------------------------------------------------------------------
  always_comb begin : operate
    inj_sign = sign_b;
    res_val  = val_a;
    nv_o     = 1'b0;

    unique case (req_i.op)
      slice_pkg::SGNJ:  inj_sign = sign_b;
      slice_pkg::SGNJN: inj_sign = ~sign_b;
      slice_pkg::SGNJX: inj_sign = sign_a ^ sign_b;
      slice_pkg::MINMAX: begin
        nv_o = snan_a | snan_b;
        if (nan_a && nan_b) begin
          res_val = (req_i.fmt == slice_pkg::FP32) ? CANON_NAN32 : {16'h0, CANON_NAN16};
        end else if (nan_a) begin
          res_val = val_b;
        end else if (nan_b) begin
          res_val = val_a;
        end else begin
          res_val = (a_lt_b ^ req_i.op_mod) ? val_a : val_b;  // op_mod flips min to max
        end
      end
    endcase

    if (req_i.op != slice_pkg::MINMAX) begin
      res_val = (req_i.fmt == slice_pkg::FP32) ? {inj_sign, mag_a}
                                               : {16'h0, inj_sign, mag_a[14:0]};
    end
  end

  assign result_o = (req_i.fmt == slice_pkg::FP32)
                  ? res_val
                  : {{slice_pkg::FP16_BITS{1'b1}}, res_val[slice_pkg::FP16_BITS-1:0]};

endmodule

// File: verilog/slice_lane.sv
/*
  One SIMD lane
  Sign-injection/min-max core followed by a valid/ready register pipeline
*/
module slice_lane #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  slice_pkg::lane_req_t    req_i,
  input  slice_pkg::slice_ctrl_t  ctrl_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  output slice_pkg::lane_rsp_t    rsp_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic                    busy_o
);

  logic [slice_pkg::LANE_BITS-1:0] core_result;
  logic                            core_nv;

  // Index i holds the item after i register stages
  slice_pkg::lane_rsp_t stage_rsp   [0:NumPipeRegs];
  logic                 stage_valid [0:NumPipeRegs];
  logic                 stage_ready [0:NumPipeRegs];

  sgnj_minmax_core i_core (
    .req_i    ( req_i       ),
    .result_o ( core_result ),
    .nv_o     ( core_nv     )
  );

  assign stage_rsp[0] = '{
    result:    core_result,
    nv:        core_nv,
    active:    req_i.active,
    fmt:       req_i.fmt,
    vectorial: ctrl_i.vectorial,
    tag:       ctrl_i.tag
  };
  assign stage_valid[0] = in_valid_i;

  // ---------------------------------------------------------------------------
  // Pipeline stages
  // ---------------------------------------------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    // Advance when the next stage is empty or drains this cycle
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_valid[i] && stage_ready[i]) begin
        stage_rsp[i+1] <= stage_rsp[i];
      end
    end
  end

  assign stage_ready[NumPipeRegs] = out_ready_i;  // Downstream ready enters at the end

  assign in_ready_o  = stage_ready[0];
  assign out_valid_o = stage_valid[NumPipeRegs];
  assign rsp_o       = stage_rsp[NumPipeRegs];

  // Input counts as in flight, same as for a lane without registers
  always_comb begin : collect_busy
    busy_o = 1'b0;
    for (int i = 0; i <= int'(NumPipeRegs); i++) begin
      busy_o = busy_o | stage_valid[i];
    end
  end

  // A stalled output keeps its item until it is taken
  stall_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(rsp_o)))
    else $error("lane output changed while stalled");

endmodule

// File: verilog/slice_pkg.sv
/*
  Shared definitions for the multi-format SIMD slice
  Formats, opcodes, lane widths and the request/response structs
*/
package slice_pkg;

  // ---------------------------------------------------------------------------
  // Widths
  // ---------------------------------------------------------------------------
  localparam int unsigned FP32_BITS = 32;
  localparam int unsigned FP16_BITS = 16;
  localparam int unsigned LANE_BITS = FP32_BITS;  // Widest format a lane handles
  localparam int unsigned SLOT_BITS = FP16_BITS;  // Narrowest slot, sets lane count
  localparam int unsigned TAG_BITS  = 4;

  // ---------------------------------------------------------------------------
  // Encodings
  // ---------------------------------------------------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic [1:0] {
    SGNJ   = 2'd0,
    SGNJN  = 2'd1,
    SGNJX  = 2'd2,
    MINMAX = 2'd3
  } operation_e;

  // Operation control as presented at the slice input
  typedef struct packed {
    operation_e          op;
    logic                op_mod;     // Selects max for MINMAX
    fp_format_e          fmt;
    logic                vectorial;
    logic [TAG_BITS-1:0] tag;
  } slice_ctrl_t;

  // Per-lane request, operands right-aligned
  typedef struct packed {
    logic [LANE_BITS-1:0] a;
    logic [LANE_BITS-1:0] b;
    operation_e           op;
    logic                 op_mod;
    fp_format_e           fmt;
    logic                 active;
  } lane_req_t;

  // Per-lane response travelling down the pipeline
  typedef struct packed {
    logic [LANE_BITS-1:0] result;
    logic                 nv;        // Invalid operation flag
    logic                 active;
    fp_format_e           fmt;
    logic                 vectorial;
    logic [TAG_BITS-1:0]  tag;
  } lane_rsp_t;

endpackage
